// File: common/axil_regs_pkg.sv
package axil_regs_pkg;

    // ----------------------------------------
    // bus widths and register window
    // ----------------------------------------
    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;
    localparam logic [AXIL_ADDR_W-1:0] AXIL_BASE_ADDR = 32'h4000_0000;

    localparam int NUM_REGS = 6;
    localparam int REG_ID_W = $clog2(NUM_REGS);

    typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0] axil_data_t;

    // axi response codes, only the two the slave ever drives
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    typedef logic [REG_ID_W-1:0] reg_id_t;

    // ----------------------------------------
    // register map
    // ----------------------------------------
    // offset is relative to AXIL_BASE_ADDR
    typedef struct packed {
        axil_addr_t offset;
        logic       memory_mapped;
        logic       clear_on_read;
        logic       trigger_on_write;
    } reg_entry_t;

    // order of entries defines the register id
    // 0x0c and anything past 0x18 stay unmapped
    localparam reg_entry_t REG_MAP [NUM_REGS] = '{
        // ctrl
        '{offset: 32'h00, memory_mapped: 1'b1, clear_on_read: 1'b0, trigger_on_write: 1'b0},
        // scratch
        '{offset: 32'h04, memory_mapped: 1'b1, clear_on_read: 1'b0, trigger_on_write: 1'b0},
        // limit
        '{offset: 32'h08, memory_mapped: 1'b1, clear_on_read: 1'b0, trigger_on_write: 1'b0},
        // status, sticky hw events, cleared by a read
        '{offset: 32'h10, memory_mapped: 1'b1, clear_on_read: 1'b1, trigger_on_write: 1'b0},
        // start, pulse only and never stored
        '{offset: 32'h14, memory_mapped: 1'b0, clear_on_read: 1'b0, trigger_on_write: 1'b1},
        // mode, stored and pulsed
        '{offset: 32'h18, memory_mapped: 1'b1, clear_on_read: 1'b0, trigger_on_write: 1'b1}
    };

    // register that accumulates hw_events
    localparam reg_id_t REG_STATUS_ID = 3;

    // result of an address lookup
    typedef struct packed {
        logic       found;
        reg_id_t    id;
        reg_entry_t entry;
    } reg_hit_t;

    // ----------------------------------------
    // channel to bank requests
    // ----------------------------------------
    typedef struct packed {
        logic       req;
        reg_id_t    id;
        axil_data_t data;
    } bank_write_t;

    typedef struct packed {
        logic    req;
        reg_id_t id;
    } bank_clear_t;

    typedef axil_data_t [NUM_REGS-1:0] reg_values_t;

    // linear scan of the map, a miss returns all zero with found low
    function automatic reg_hit_t decode_reg_addr(axil_addr_t addr);
        reg_hit_t   hit;
        axil_addr_t offset;
        hit    = '0;
        offset = addr - AXIL_BASE_ADDR;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (REG_MAP[i].offset == offset) begin
                hit.found = 1'b1;
                hit.id    = reg_id_t'(i);
                hit.entry = REG_MAP[i];
            end
        end
        return hit;
    endfunction

endpackage

// File: rtl/axil_read_channel.sv
`timescale 1ns/10ps

module axil_read_channel
    import axil_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // AR channel
    input  logic        arvalid,
    input  axil_addr_t  araddr,
    output logic        arready,

    // R channel
    output logic        rvalid,
    input  logic        rready,
    output axil_data_t  rdata,
    output axil_resp_t  rresp,

    // register bank side
    input  reg_values_t reg_values,
    output bank_clear_t clear_req
);

    typedef enum logic [1:0] {
        RD_READY,
        RD_FETCH,
        RD_VALID
    } rd_state_t;

    rd_state_t  state;
    rd_state_t  state_next;
    axil_addr_t araddr_q;
    reg_hit_t   rd_hit;
    logic       ar_hs;
    logic       r_hs;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign arready = (state == RD_READY);
    assign rvalid  = (state == RD_VALID);
    assign ar_hs   = arvalid & arready;
    assign r_hs    = rvalid & rready;

    // ----------------------------------------
    // fsm
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_READY;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RD_READY: if (ar_hs) state_next = RD_FETCH;
            // always exactly one fetch cycle
            RD_FETCH: state_next = RD_VALID;
            RD_VALID: if (r_hs) state_next = RD_READY;
            default:  state_next = RD_READY;
        endcase
    end

    // ----------------------------------------
    // address capture and decode
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            araddr_q <= araddr;
        end
    end

    // map lookup works on the registered address, off the bus path
    assign rd_hit = decode_reg_addr(araddr_q);

    // ----------------------------------------
    // response and clear-on-read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rresp     <= SLVERR;
            clear_req <= '0;
        end else begin
            // clear request is a single cycle pulse
            clear_req.req <= 1'b0;
            if (state == RD_FETCH) begin
                if (rd_hit.found) begin
                    rdata         <= reg_values[rd_hit.id];
                    rresp         <= OKAY;
                    clear_req.req <= rd_hit.entry.clear_on_read;
                    clear_req.id  <= rd_hit.id;
                end else begin
                    rdata <= '0;
                    rresp <= SLVERR;
                end
            end else if (r_hs) begin
                // idle value between transfers
                rresp <= SLVERR;
            end
        end
    end

endmodule

// File: rtl/axil_write_channel.sv
`timescale 1ns/10ps

module axil_write_channel
    import axil_regs_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // AW channel
    input  logic                awvalid,
    input  axil_addr_t          awaddr,
    output logic                awready,

    // W channel
    input  logic                wvalid,
    input  axil_data_t          wdata,
    output logic                wready,

    // B channel
    output logic                bvalid,
    input  logic                bready,
    output axil_resp_t          bresp,

    // register bank side
    output bank_write_t         write_req,
    output logic [NUM_REGS-1:0] write_trigger
);

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    wr_state_t  state;
    wr_state_t  state_next;
    axil_addr_t awaddr_q;
    reg_hit_t   wr_hit;
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    // wready only after the address is taken, W before AW just waits
    assign awready = (state == WR_ADDR);
    assign wready  = (state == WR_DATA);
    assign bvalid  = (state == WR_RESP);
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;
    assign b_hs    = bvalid & bready;

    // unmapped writes are answered OKAY as well
    assign bresp = (state == WR_RESP) ? OKAY : SLVERR;

    // ----------------------------------------
    // fsm
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_ADDR;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WR_ADDR: if (aw_hs) state_next = WR_DATA;
            WR_DATA: if (w_hs) state_next = WR_RESP;
            WR_RESP: if (b_hs) state_next = WR_ADDR;
            default: state_next = WR_ADDR;
        endcase
    end

    // ----------------------------------------
    // address capture and decode
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= awaddr;
        end
    end

    // decode settles while waiting for W
    assign wr_hit = decode_reg_addr(awaddr_q);

    // ----------------------------------------
    // bank write and trigger pulses
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            write_req     <= '0;
            write_trigger <= '0;
        end else begin
            // both are one cycle pulses
            write_req.req <= 1'b0;
            write_trigger <= '0;
            if (w_hs) begin
                write_req.id   <= wr_hit.id;
                write_req.data <= wdata;
                if (wr_hit.found) begin
                    write_req.req                <= wr_hit.entry.memory_mapped;
                    write_trigger[wr_hit.id]     <= wr_hit.entry.trigger_on_write;
                end
            end
        end
    end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/10ps

module reg_bank
    import axil_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // requests from the two channels
    input  bank_write_t write_req,
    input  bank_clear_t clear_req,

    // sticky event inputs for the status register
    input  axil_data_t  hw_events,

    output reg_values_t reg_values
);

    reg_values_t values_next;

    // ----------------------------------------
    // merge of write, clear and events
    // ----------------------------------------
    always_comb begin
        values_next = reg_values;
        for (int i = 0; i < NUM_REGS; i++) begin
            // a write on the same id beats a clear
            if (write_req.req && write_req.id == reg_id_t'(i)) begin
                values_next[i] = write_req.data;
            end else if (clear_req.req && clear_req.id == reg_id_t'(i)) begin
                values_next[i] = '0;
            end
        end
        // events OR in after the clear, so bits arriving in the
        // clearing cycle are kept
        values_next[REG_STATUS_ID] = values_next[REG_STATUS_ID] | hw_events;
    end

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_values <= '0;
        end else begin
            reg_values <= values_next;
        end
    end

endmodule

// File: rtl/axil_reg_slave.sv
`timescale 1ns/10ps

module axil_reg_slave
    import axil_regs_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,

    // ----------------------------------------
    // axi4-lite slave port
    // ----------------------------------------
    input  logic                awvalid,
    input  axil_addr_t          awaddr,
    output logic                awready,
    input  logic                wvalid,
    input  axil_data_t          wdata,
    output logic                wready,
    output logic                bvalid,
    input  logic                bready,
    output axil_resp_t          bresp,
    input  logic                arvalid,
    input  axil_addr_t          araddr,
    output logic                arready,
    output logic                rvalid,
    input  logic                rready,
    output axil_data_t          rdata,
    output axil_resp_t          rresp,

    // ----------------------------------------
    // hardware side
    // ----------------------------------------
    input  axil_data_t          hw_events,
    output reg_values_t         reg_values,
    output logic [NUM_REGS-1:0] write_trigger
);

    bank_write_t write_req;
    bank_clear_t clear_req;

    // read path, also issues clear-on-read requests
    axil_read_channel u_read_channel (
        .clk        (clk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .reg_values (reg_values),
        .clear_req  (clear_req)
    );

    // write path, runs independently of the read path
    axil_write_channel u_write_channel (
        .clk           (clk),
        .rst_n         (rst_n),
        .awvalid       (awvalid),
        .awaddr        (awaddr),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .write_req     (write_req),
        .write_trigger (write_trigger)
    );

    // bank contents go both to readback and out to the hardware
    reg_bank u_reg_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .write_req  (write_req),
        .clear_req  (clear_req),
        .hw_events  (hw_events),
        .reg_values (reg_values)
    );

endmodule

// File: dv/axil_reg_slave_checks.sv
`timescale 1ns/10ps

module axil_reg_slave_checks
    import axil_regs_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic                arvalid,
    input logic                arready,
    input logic                rvalid,
    input logic                rready,
    input axil_data_t          rdata,
    input axil_resp_t          rresp,
    input logic                awvalid,
    input logic                awready,
    input logic                wready,
    input logic                bvalid,
    input logic                bready,
    input axil_resp_t          bresp,
    input logic [NUM_REGS-1:0] write_trigger
);

    // raised by any failing property and watched by the testbench top
    logic check_failed = 1'b0;

    task automatic flag_violation(input string what);
        check_failed = 1'b1;
        $error("%s", what);
    endtask

    // ----------------------------------------
    // read channel
    // ----------------------------------------
    // payload holds under back-pressure
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else flag_violation("rvalid, rdata or rresp changed while rready was low");

    ar_lock: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> !arready)
        else flag_violation("arready stayed high after the AR handshake");

    // busy until the R handshake
    ar_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !arready && !(rvalid && rready) |=> !arready)
        else flag_violation("arready rose before the R handshake");

    ar_release: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready |=> arready)
        else flag_violation("arready did not return after the R handshake");

    // one fetch cycle before the data
    r_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |=> !rvalid)
        else flag_violation("rvalid rose during the fetch cycle");

    r_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(arvalid && arready) |=> rvalid)
        else flag_violation("rvalid missing two cycles after the AR handshake");

    r_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(arvalid && arready, 2))
        else flag_violation("rvalid rose without an AR handshake two cycles before");

    // ----------------------------------------
    // write channel
    // ----------------------------------------
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else flag_violation("bvalid or bresp changed while bready was low");

    aw_lock: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && awready |=> !awready)
        else flag_violation("awready stayed high after the AW handshake");

    aw_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !awready && !(bvalid && bready) |=> !awready)
        else flag_violation("awready rose before the B handshake");

    aw_release: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && bready |=> awready)
        else flag_violation("awready did not return after the B handshake");

    // W is only taken once the address is in
    w_order: assert property (@(posedge clk) disable iff (!rst_n)
        wready |-> !awready)
        else flag_violation("wready high while awready was still high");

    b_okay: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid |-> bresp == OKAY)
        else begin
            check_failed = 1'b1;
            $error("FAILED bresp exp=%h got=%h", OKAY, bresp);
        end

    // trigger is a single cycle pulse alongside the rising bvalid
    trig_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (|write_trigger) |=> (write_trigger == '0))
        else flag_violation("write_trigger stayed high for more than one cycle");

    trig_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (|write_trigger) |-> $rose(bvalid))
        else flag_violation("write_trigger pulsed outside the first response cycle");

endmodule

// File: dv/axil_reg_slave_tb.sv
`timescale 1ns/10ps

module axil_reg_slave_tb
    import axil_regs_pkg::*;
();

    // about 80 transactions of at most 20 cycles each
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int MAX_STALL      = 5;

    logic                clk;
    logic                rst_n;
    logic                awvalid;
    axil_addr_t          awaddr;
    logic                awready;
    logic                wvalid;
    axil_data_t          wdata;
    logic                wready;
    logic                bvalid;
    logic                bready;
    axil_resp_t          bresp;
    logic                arvalid;
    axil_addr_t          araddr;
    logic                arready;
    logic                rvalid;
    logic                rready;
    axil_data_t          rdata;
    axil_resp_t          rresp;
    axil_data_t          hw_events;
    reg_values_t         reg_values;
    logic [NUM_REGS-1:0] write_trigger;

    // expected register contents
    axil_data_t  model [NUM_REGS];
    logic [31:0] rng_state;
    int unsigned cycle_count;

    axil_reg_slave dut (.*);

    bind axil_reg_slave axil_reg_slave_checks u_checks (
        .clk           (clk),
        .rst_n         (rst_n),
        .arvalid       (arvalid),
        .arready       (arready),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .awvalid       (awvalid),
        .awready       (awready),
        .wready        (wready),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .write_trigger (write_trigger)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    // ----------------------------------------
    // timeout and bound checker watch
    // ----------------------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (dut.u_checks.check_failed) begin
            abort_run();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value     = rng_state;
    endtask

    // register id for each offset of the map
    // an unmapped offset gives -1
    function automatic int offset_to_id(input logic [31:0] offset);
        case (offset)
            32'h00:  return 0;
            32'h04:  return 1;
            32'h08:  return 2;
            32'h10:  return 3;
            32'h14:  return 4;
            32'h18:  return 5;
            default: return -1;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s exp=%h got=%h", name, exp, got);
            abort_run();
        end
    endtask

    task automatic check_bank();
        for (int i = 0; i < NUM_REGS; i++) begin
            check_word($sformatf("reg_values[%0d]", i), reg_values[reg_id_t'(i)],
                       model[reg_id_t'(i)]);
        end
    endtask

    // ----------------------------------------
    // bus tasks enter and leave on a falling edge
    // ----------------------------------------
    task automatic axi_write(input logic [31:0] offset, input axil_data_t data,
                             output axil_resp_t resp, output logic [NUM_REGS-1:0] trig_first,
                             output logic [NUM_REGS-1:0] trig_next);
        logic [31:0] r;
        draw_random(r);
        awvalid = 1'b1;
        awaddr  = AXIL_BASE_ADDR + offset;
        wvalid  = 1'b1;
        wdata   = data;
        bready  = 1'b0;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        while (!wready) @(negedge clk);
        @(negedge clk);
        wvalid = 1'b0;
        // trigger in the first response cycle and in the one after
        trig_first = write_trigger;
        @(negedge clk);
        trig_next = write_trigger;
        repeat (r % (MAX_STALL + 1)) @(negedge clk);
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] offset, output axil_data_t data,
                            output axil_resp_t resp);
        logic [31:0] r;
        draw_random(r);
        arvalid = 1'b1;
        araddr  = AXIL_BASE_ADDR + offset;
        rready  = 1'b0;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        assert (rvalid === 1'b0) else begin
            $display("rvalid was already high in the fetch cycle");
            abort_run();
        end
        @(negedge clk);
        assert (rvalid === 1'b1) else begin
            $display("rvalid did not rise two cycles after the AR handshake");
            abort_run();
        end
        repeat (r % (MAX_STALL + 1)) @(negedge clk);
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // ----------------------------------------
    // model-checked transactions
    // ----------------------------------------
    task automatic write_checked(input logic [31:0] offset, input axil_data_t data);
        int                  id;
        axil_resp_t          resp;
        logic [NUM_REGS-1:0] trig_first;
        logic [NUM_REGS-1:0] trig_next;
        logic [NUM_REGS-1:0] exp_trig;
        id       = offset_to_id(offset);
        exp_trig = '0;
        if (id >= 0) begin
            // start only pulses while mode stores and pulses
            if (id != 4) model[reg_id_t'(id)] = data;
            if (id == 4 || id == 5) exp_trig[reg_id_t'(id)] = 1'b1;
        end
        axi_write(offset, data, resp, trig_first, trig_next);
        check_word("bresp", 32'(resp), 32'(OKAY));
        check_word("write_trigger", 32'(trig_first), 32'(exp_trig));
        check_word("write_trigger", 32'(trig_next), '0);
        check_bank();
    endtask

    task automatic read_checked(input logic [31:0] offset);
        int         id;
        axil_data_t data;
        axil_resp_t resp;
        id = offset_to_id(offset);
        axi_read(offset, data, resp);
        if (id < 0) begin
            check_word("rresp", 32'(resp), 32'(SLVERR));
        end else begin
            check_word("rresp", 32'(resp), 32'(OKAY));
            check_word("rdata", data, model[reg_id_t'(id)]);
            // status clears on read
            if (id == 3) model[reg_id_t'(id)] = '0;
        end
        check_bank();
    endtask

    task automatic pulse_events(input axil_data_t bits);
        hw_events = bits;
        model[REG_STATUS_ID] = model[REG_STATUS_ID] | bits;
        @(negedge clk);
        hw_events = '0;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        clk         = 1'b0;
        rst_n       = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        bready      = 1'b0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        hw_events   = '0;
        rng_state   = 32'd33;
        cycle_count = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[reg_id_t'(i)] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state
        check_word("arready", 32'(arready), 32'd1);
        check_word("awready", 32'(awready), 32'd1);
        check_word("rvalid", 32'(rvalid), '0);
        check_word("wready", 32'(wready), '0);
        check_word("bvalid", 32'(bvalid), '0);
        check_word("write_trigger", 32'(write_trigger), '0);
        check_word("rresp", 32'(rresp), 32'(SLVERR));
        check_word("bresp", 32'(bresp), 32'(SLVERR));
        check_bank();

        // write and readback on ctrl, scratch and limit
        for (int i = 0; i < 10; i++) begin
            draw_random(r);
            draw_random(d);
            write_checked((r % 3) << 2, d);
            draw_random(r);
            read_checked((r % 3) << 2);
        end

        // unmapped offsets
        read_checked(32'h0C);
        read_checked(32'h1C);
        draw_random(d);
        write_checked(32'h0C, d);
        draw_random(d);
        write_checked(32'h1C, d);

        // start and mode triggers
        for (int i = 0; i < 3; i++) begin
            draw_random(d);
            write_checked(32'h14, d);
            read_checked(32'h14);
            draw_random(d);
            write_checked(32'h18, d);
            read_checked(32'h18);
        end

        // sticky status is cleared by a read
        for (int i = 0; i < 4; i++) begin
            draw_random(d);
            pulse_events(d);
            draw_random(d);
            pulse_events(d);
            check_bank();
            read_checked(32'h10);
            read_checked(32'h10);
        end

        // random mix over the whole window with stalls in every transaction
        for (int i = 0; i < 24; i++) begin
            draw_random(r);
            draw_random(d);
            if (r[16]) begin
                write_checked(32'({r[2:0], 2'b00}), d);
            end else begin
                read_checked(32'({r[2:0], 2'b00}));
            end
        end

        @(negedge clk);
        if (dut.u_checks.check_failed) begin
            abort_run();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: vlog.f
common/axil_regs_pkg.sv
rtl/axil_read_channel.sv
rtl/axil_write_channel.sv
rtl/reg_bank.sv
rtl/axil_reg_slave.sv
dv/axil_reg_slave_checks.sv
dv/axil_reg_slave_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the AXI4-Lite register slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert \
    --top-module axil_reg_slave_tb \
    -f vlog.f \
    -Mdir obj_dir -o axil_reg_slave_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/axil_reg_slave_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"

if grep -q "=== FAIL ===" "$sim_log"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
